/* logic/uart_dbg_pkg.sv */
package uart_dbg_pkg;

  // UART bit timing in system clocks
  localparam int CLKS_PER_BIT = 16;
  localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

  // Byte count of every address or length field
  localparam int FIELD_BYTES = 8;

  typedef logic [7:0]  byte_t;
  typedef logic [63:0] dbg_addr_t;

  ////////////////////////////////////////
  // Protocol byte codes
  ////////////////////////////////////////

  localparam byte_t CMD_READ  = 8'h11;
  localparam byte_t CMD_WRITE = 8'h12;
  localparam byte_t CMD_EXEC  = 8'h13;
  localparam byte_t DBG_ACK   = 8'h06;
  localparam byte_t DBG_EOT   = 8'h04;

endpackage

/* logic/mem_bus_pkg.sv */
package mem_bus_pkg;

  // Geometry of the shared debug memory
  localparam int MEM_AW    = 10;
  localparam int MEM_DEPTH = 1 << MEM_AW;
  localparam int MEM_DW    = 8;

  typedef logic [MEM_AW-1:0] mem_addr_t;

  // Peer to arbiter, held stable while req is high
  typedef struct packed {
    logic              req;
    logic              we;
    mem_addr_t         addr;
    logic [MEM_DW-1:0] wdata;
  } mem_req_t;

  // Arbiter to peer, rdata valid while ack is high
  typedef struct packed {
    logic              ack;
    logic [MEM_DW-1:0] rdata;
  } mem_rsp_t;

endpackage

/* logic/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx import uart_dbg_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  rx_i,
  output logic  rx_valid_o,
  output byte_t rx_byte_o
);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e            state_q;
  logic [1:0]           sync_q;
  logic                 prev_q;
  logic [BIT_CNT_W-1:0] cnt_q;
  logic [2:0]           bit_q;
  logic                 valid_q;
  byte_t                shift_q;
  logic                 bit_end;
  logic                 sample;

  assign sample  = sync_q[1];
  assign bit_end = (cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q  <= 2'b11;
      prev_q  <= 1'b1;
      state_q <= RX_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], rx_i};
      prev_q  <= sample;
      valid_q <= 1'b0;
      cnt_q   <= cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (prev_q && !sample) state_q <= RX_START;
        end
        // Half a bit to reach the middle of the start bit
        RX_START: begin
          if (cnt_q == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            state_q <= sample ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) state_q <= RX_STOP;
          end
        end
        // Broken frames never raise the strobe
        RX_STOP: begin
          if (bit_end) begin
            valid_q <= sample;
            state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && bit_end) shift_q <= {sample, shift_q[7:1]};
  end

  assign rx_valid_o = valid_q;
  assign rx_byte_o  = shift_q;

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx import uart_dbg_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  tx_start_i,
  input  byte_t tx_byte_i,
  output logic  tx_ready_o,
  output logic  tx_o
);

  logic                 busy_q;
  logic [BIT_CNT_W-1:0] cnt_q;
  logic [3:0]           idx_q;
  logic [9:0]           frame_q;
  logic                 bit_end;

  assign bit_end = busy_q && (cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));

  // Frame is stop, data LSB first, start; idle shifts in ones
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      cnt_q   <= '0;
      idx_q   <= '0;
      frame_q <= '1;
    end else if (!busy_q) begin
      if (tx_start_i) begin
        busy_q  <= 1'b1;
        cnt_q   <= '0;
        idx_q   <= '0;
        frame_q <= {1'b1, tx_byte_i, 1'b0};
      end
    end else if (bit_end) begin
      cnt_q   <= '0;
      idx_q   <= idx_q + 1'b1;
      frame_q <= {1'b1, frame_q[9:1]};
      if (idx_q == 4'd9) busy_q <= 1'b0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign tx_o       = frame_q[0];
  assign tx_ready_o = !busy_q;

  // The engine must honour the ready handshake
  a_start_when_ready: assert property (
    @(posedge clk) disable iff (!rst_n_i) tx_start_i |-> tx_ready_o
  ) else $error("uart_tx: start while busy");

endmodule

/* logic/dbg_cmd_engine.sv */
`timescale 1ns/1ps

module dbg_cmd_engine import uart_dbg_pkg::*, mem_bus_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      rx_valid_i,
  input  byte_t     rx_byte_i,
  input  logic      tx_ready_i,
  output logic      tx_start_o,
  output byte_t     tx_byte_o,
  output mem_req_t  mem_req_o,
  input  mem_rsp_t  mem_rsp_i,
  output logic      exec_valid_o,
  output dbg_addr_t exec_addr_o
);

  typedef enum logic [3:0] {
    ST_IDLE, ST_ADDR, ST_LEN, ST_ACK, ST_RD_REQ, ST_RD_WAIT,
    ST_RD_SEND, ST_WR_WAIT, ST_WR_ACK, ST_EOT
  } eng_state_e;

  eng_state_e                     state_q;
  byte_t                          cmd_q;
  logic [$clog2(FIELD_BYTES)-1:0] fld_cnt_q;
  dbg_addr_t                      field_q;
  dbg_addr_t                      field_next;
  mem_addr_t                      addr_q;
  mem_addr_t                      len_q;
  logic                           req_q;
  byte_t                          wdata_q;
  byte_t                          rdata_q;
  logic                           tx_start_q;
  byte_t                          tx_byte_q;
  byte_t                          tx_byte_d;
  logic                           exec_valid_q;
  logic                           fld_last;
  logic                           is_cmd;
  logic                           tx_go;

  // Little-endian fields, first byte ends up lowest
  assign field_next = {rx_byte_i, field_q[$bits(dbg_addr_t)-1:8]};
  assign fld_last   = (fld_cnt_q == $bits(fld_cnt_q)'(FIELD_BYTES - 1));
  assign is_cmd     = (rx_byte_i == CMD_READ) || (rx_byte_i == CMD_WRITE) ||
                      (rx_byte_i == CMD_EXEC);

  // tx_ready lags one cycle behind our own start pulse
  assign tx_go = tx_ready_i && !tx_start_q &&
                 (state_q == ST_ACK || state_q == ST_RD_SEND || state_q == ST_EOT);

  always_comb begin
    case (state_q)
      ST_RD_SEND: tx_byte_d = rdata_q;
      ST_EOT:     tx_byte_d = DBG_EOT;
      default:    tx_byte_d = DBG_ACK;
    endcase
  end

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= ST_IDLE;
      cmd_q        <= '0;
      fld_cnt_q    <= '0;
      addr_q       <= '0;
      len_q        <= '0;
      req_q        <= 1'b0;
      tx_start_q   <= 1'b0;
      exec_valid_q <= 1'b0;
    end else begin
      tx_start_q   <= tx_go;
      exec_valid_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (rx_valid_i) begin
            cmd_q     <= rx_byte_i;
            fld_cnt_q <= '0;
            if (rx_byte_i == DBG_ACK) state_q <= ST_ACK;
            else if (is_cmd) state_q <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (rx_valid_i) begin
            fld_cnt_q <= fld_cnt_q + 1'b1;
            if (fld_last) begin
              addr_q  <= field_next[MEM_AW-1:0];
              state_q <= (cmd_q == CMD_EXEC) ? ST_ACK : ST_LEN;
            end
          end
        end
        ST_LEN: begin
          if (rx_valid_i) begin
            fld_cnt_q <= fld_cnt_q + 1'b1;
            if (fld_last) begin
              len_q   <= field_next[MEM_AW-1:0];
              state_q <= ST_ACK;
            end
          end
        end
        ST_ACK: begin
          if (tx_go) begin
            exec_valid_q <= (cmd_q == CMD_EXEC);
            if (cmd_q == CMD_READ || cmd_q == CMD_WRITE) begin
              if (len_q == '0) state_q <= ST_EOT;
              else state_q <= (cmd_q == CMD_READ) ? ST_RD_REQ : ST_WR_WAIT;
            end else begin
              state_q <= ST_IDLE;
            end
          end
        end
        // Previous ack must be gone before a new request
        ST_RD_REQ: begin
          if (!mem_rsp_i.ack) begin
            req_q   <= 1'b1;
            state_q <= ST_RD_WAIT;
          end
        end
        ST_RD_WAIT: begin
          if (mem_rsp_i.ack) begin
            req_q   <= 1'b0;
            addr_q  <= addr_q + 1'b1;
            state_q <= ST_RD_SEND;
          end
        end
        ST_RD_SEND: begin
          if (tx_go) begin
            len_q   <= len_q - 1'b1;
            state_q <= (len_q == mem_addr_t'(1)) ? ST_EOT : ST_RD_REQ;
          end
        end
        ST_WR_WAIT: begin
          if (rx_valid_i) begin
            req_q   <= 1'b1;
            state_q <= ST_WR_ACK;
          end
        end
        ST_WR_ACK: begin
          if (mem_rsp_i.ack) begin
            req_q   <= 1'b0;
            addr_q  <= addr_q + 1'b1;
            len_q   <= len_q - 1'b1;
            state_q <= (len_q == mem_addr_t'(1)) ? ST_EOT : ST_WR_WAIT;
          end
        end
        ST_EOT: begin
          if (tx_go) state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Data path
  always_ff @(posedge clk) begin
    if (rx_valid_i && (state_q == ST_ADDR || state_q == ST_LEN)) field_q <= field_next;
    if (rx_valid_i && state_q == ST_WR_WAIT) wdata_q <= rx_byte_i;
    if (state_q == ST_RD_WAIT && mem_rsp_i.ack) rdata_q <= mem_rsp_i.rdata;
    if (tx_go) tx_byte_q <= tx_byte_d;
  end

  assign mem_req_o = '{req: req_q, we: (cmd_q == CMD_WRITE), addr: addr_q, wdata: wdata_q};

  assign tx_start_o   = tx_start_q;
  assign tx_byte_o    = tx_byte_q;
  assign exec_valid_o = exec_valid_q;
  assign exec_addr_o  = field_q;

  // Request must not move until the arbiter answers
  a_req_stable: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (mem_req_o.req && !mem_rsp_i.ack) |=> (mem_req_o.req && $stable(mem_req_o))
  ) else $error("dbg_cmd_engine: request changed before ack");

endmodule

/* logic/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter import mem_bus_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  mem_req_t          req0_i,
  output mem_rsp_t          rsp0_o,
  input  mem_req_t          req1_i,
  output mem_rsp_t          rsp1_o,
  output logic              mem_en_o,
  output logic              mem_we_o,
  output mem_addr_t         mem_addr_o,
  output logic [MEM_DW-1:0] mem_wdata_o,
  input  logic [MEM_DW-1:0] mem_rdata_i
);

  typedef enum logic [1:0] {ARB_IDLE, ARB_ACCESS, ARB_ACK} arb_state_e;

  arb_state_e state_q;
  logic       owner_q;
  logic       winner;
  logic       ack;
  mem_req_t   owner_req;

  // On a tie the peer that lost last time goes first
  assign winner    = (req0_i.req && req1_i.req) ? !owner_q : req1_i.req;
  assign owner_req = owner_q ? req1_i : req0_i;
  assign ack       = (state_q == ARB_ACK);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ARB_IDLE;
      owner_q <= 1'b1;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (req0_i.req || req1_i.req) begin
            owner_q <= winner;
            state_q <= ARB_ACCESS;
          end
        end
        ARB_ACCESS: state_q <= ARB_ACK;
        // Grant holds until the owner drops req
        ARB_ACK: if (!owner_req.req) state_q <= ARB_IDLE;
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  assign mem_en_o    = (state_q == ARB_ACCESS);
  assign mem_we_o    = owner_req.we;
  assign mem_addr_o  = owner_req.addr;
  assign mem_wdata_o = owner_req.wdata;

  assign rsp0_o = '{ack: ack && !owner_q, rdata: mem_rdata_i};
  assign rsp1_o = '{ack: ack && owner_q, rdata: mem_rdata_i};

  // Each peer keeps its request up until its own ack arrives
  a_req0_held: assert property (
    @(posedge clk) disable iff (!rst_n_i) (req0_i.req && !rsp0_o.ack) |=> req0_i.req
  ) else $error("mem_arbiter: port 0 dropped req before ack");

  a_req1_held: assert property (
    @(posedge clk) disable iff (!rst_n_i) (req1_i.req && !rsp1_o.ack) |=> req1_i.req
  ) else $error("mem_arbiter: port 1 dropped req before ack");

endmodule

/* logic/dbg_sram.sv */
`timescale 1ns/1ps

module dbg_sram import mem_bus_pkg::*; (
  input  logic              clk,
  input  logic              mem_en_i,
  input  logic              mem_we_i,
  input  mem_addr_t         mem_addr_i,
  input  logic [MEM_DW-1:0] mem_wdata_i,
  output logic [MEM_DW-1:0] mem_rdata_o
);

  logic [MEM_DW-1:0] mem_q [MEM_DEPTH];
  logic [MEM_DW-1:0] rdata_q;

  // Read data holds until the next read
  always_ff @(posedge clk) begin
    if (mem_en_i) begin
      if (mem_we_i) mem_q[mem_addr_i] <= mem_wdata_i;
      else rdata_q <= mem_q[mem_addr_i];
    end
  end

  assign mem_rdata_o = rdata_q;

endmodule

/* logic/dbg_bridge_top.sv */
`timescale 1ns/1ps

module dbg_bridge_top import uart_dbg_pkg::*, mem_bus_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      uart_rx_i,
  output logic      uart_tx_o,
  input  mem_req_t  host_req_i,
  output mem_rsp_t  host_rsp_o,
  output logic      exec_valid_o,
  output dbg_addr_t exec_addr_o
);

  logic      rx_valid;
  byte_t     rx_byte;
  logic      tx_start;
  logic      tx_ready;
  byte_t     tx_byte;
  mem_req_t  eng_req;
  mem_rsp_t  eng_rsp;
  logic      mem_en;
  logic      mem_we;
  mem_addr_t mem_addr;
  byte_t     mem_wdata;
  byte_t     mem_rdata;

  ////////////////////////////////////////
  // UART side
  ////////////////////////////////////////

  uart_rx u_uart_rx (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rx_i       (uart_rx_i),
    .rx_valid_o (rx_valid),
    .rx_byte_o  (rx_byte)
  );

  uart_tx u_uart_tx (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .tx_start_i (tx_start),
    .tx_byte_i  (tx_byte),
    .tx_ready_o (tx_ready),
    .tx_o       (uart_tx_o)
  );

  dbg_cmd_engine u_engine (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .rx_valid_i   (rx_valid),
    .rx_byte_i    (rx_byte),
    .tx_ready_i   (tx_ready),
    .tx_start_o   (tx_start),
    .tx_byte_o    (tx_byte),
    .mem_req_o    (eng_req),
    .mem_rsp_i    (eng_rsp),
    .exec_valid_o (exec_valid_o),
    .exec_addr_o  (exec_addr_o)
  );

  ////////////////////////////////////////
  // Shared memory
  ////////////////////////////////////////

  // Port 0 is the engine, port 1 the external host
  mem_arbiter u_arbiter (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req0_i      (eng_req),
    .rsp0_o      (eng_rsp),
    .req1_i      (host_req_i),
    .rsp1_o      (host_rsp_o),
    .mem_en_o    (mem_en),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata)
  );

  dbg_sram u_sram (
    .clk         (clk),
    .mem_en_i    (mem_en),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_rdata_o (mem_rdata)
  );

endmodule

/* bench/tb_dbg_bridge.sv */
`timescale 1ns/1ps

module tb_dbg_bridge import uart_dbg_pkg::*, mem_bus_pkg::*; ();

  localparam int NUM_ROWS     = 9;
  localparam int ACK_TIMEOUT  = 64;
  localparam int BYTE_TIMEOUT = 40 * 10 * CLKS_PER_BIT;
  localparam int QUIET_CYCLES = 20 * CLKS_PER_BIT;
  localparam int HOST_OFFSET  = 'h200;

  typedef enum logic [2:0] {
    K_CHALLENGE, K_UART_WRITE, K_UART_READ, K_EXEC, K_BAD_BYTE
  } kind_e;

  // Data holds the bytes that UART or the host port writes
  typedef struct packed {
    kind_e           kind;
    dbg_addr_t       addr;
    logic [7:0]      len;
    logic [7:0][7:0] data;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        uart_rx;
  logic        uart_tx;
  mem_req_t    host_req;
  mem_rsp_t    host_rsp;
  logic        exec_valid;
  dbg_addr_t   exec_addr;

  row_t        rows [NUM_ROWS];
  byte_t       ref_mem [MEM_DEPTH];
  byte_t       sent_q [$];
  byte_t       got_q [$];
  byte_t       exp_q [$];
  logic [31:0] rng_state = 32'hb3b1b49d;
  int          exec_cnt;
  dbg_addr_t   exec_seen;
  logic        uart_busy;

  dbg_bridge_top dut (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .uart_rx_i    (uart_rx),
    .uart_tx_o    (uart_tx),
    .host_req_i   (host_req),
    .host_rsp_o   (host_rsp),
    .exec_valid_o (exec_valid),
    .exec_addr_o  (exec_addr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Exec pulse monitor
  initial begin
    exec_cnt  = 0;
    exec_seen = '0;
    forever begin
      @(negedge clk);
      if (exec_valid) begin
        exec_cnt++;
        exec_seen = exec_addr;
      end
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic row_t make_row(kind_e kind, dbg_addr_t addr, int len);
    row_t r;
    r.kind = kind;
    r.addr = addr;
    r.len  = 8'(len);
    for (int i = 0; i < 8; i++) begin
      r.data[i] = byte_t'(next_rand());
    end
    return r;
  endfunction

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic await_host_ack(input logic level, output byte_t rdata);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (host_rsp.ack !== level && n < ACK_TIMEOUT);
    assert (host_rsp.ack === level) else begin
      $display("Timed out after %0d cycles waiting for host ack to go %0b", n, level);
      abort_run();
    end
    rdata = host_rsp.rdata;
  endtask

  task automatic host_write(input mem_addr_t a, input byte_t d);
    byte_t ignored;
    @(posedge clk);
    host_req <= '{req: 1'b1, we: 1'b1, addr: a, wdata: d};
    await_host_ack(1'b1, ignored);
    @(posedge clk);
    host_req.req <= 1'b0;
    await_host_ack(1'b0, ignored);
  endtask

  task automatic host_read(input mem_addr_t a, output byte_t d);
    byte_t ignored;
    @(posedge clk);
    host_req <= '{req: 1'b1, we: 1'b0, addr: a, wdata: 8'h00};
    await_host_ack(1'b1, d);
    @(posedge clk);
    host_req.req <= 1'b0;
    await_host_ack(1'b0, ignored);
  endtask

  task automatic check_host_byte(input mem_addr_t a);
    byte_t got;
    host_read(a, got);
    assert (got === ref_mem[a]) else begin
      $display("mismatch @%0t: host read of %03h gave %02h, expected %02h",
               $time, a, got, ref_mem[a]);
      abort_run();
    end
  endtask

  // 8N1 frame, LSB first
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx <= frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic recv_byte(output byte_t b);
    int    n;
    byte_t data;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (uart_tx !== 1'b0 && n < BYTE_TIMEOUT);
    assert (uart_tx === 1'b0) else begin
      $display("Timed out waiting for a start bit on the UART output");
      abort_run();
    end
    // Move to mid start bit, then one bit period per sample
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    assert (uart_tx === 1'b0) else begin
      $display("The start bit from the DUT ended too early");
      abort_run();
    end
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      data[i] = uart_tx;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    assert (uart_tx === 1'b1) else begin
      $display("A UART frame from the DUT has a low stop bit");
      abort_run();
    end
    b = data;
  endtask

  task automatic expect_silence(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      assert (uart_tx === 1'b1) else begin
        $display("The DUT sent a byte where no reply was expected");
        abort_run();
      end
    end
  endtask

  // Dense host traffic on its own region for as long as UART bytes go in
  task automatic host_traffic(input int base, input int len);
    mem_addr_t a;
    byte_t     d;
    while (uart_busy) begin
      for (int i = 0; i < len; i++) begin
        repeat (next_rand() % 8) @(posedge clk);
        a = mem_addr_t'(base + i);
        d = byte_t'(next_rand());
        ref_mem[a] = d;
        host_write(a, d);
      end
      for (int i = 0; i < len; i++) begin
        check_host_byte(mem_addr_t'(base + i));
      end
    end
  endtask

  function automatic void push_header(byte_t cmd, row_t r);
    sent_q.push_back(cmd);
    for (int k = 0; k < FIELD_BYTES; k++) begin
      sent_q.push_back(r.addr[8*k +: 8]);
    end
    if (cmd != CMD_EXEC) begin
      for (int k = 0; k < FIELD_BYTES; k++) begin
        sent_q.push_back((k == 0) ? r.len : 8'h00);
      end
    end
  endfunction

  ////////////////////////////////////////
  // One table row
  ////////////////////////////////////////

  task automatic run_row(input int idx, input row_t r);
    int    base;
    int    host_base;
    int    len;
    int    exec_before;
    byte_t b;
    base        = int'(r.addr[MEM_AW-1:0]);
    host_base   = base + HOST_OFFSET;
    len         = int'(r.len);
    exec_before = exec_cnt;
    sent_q.delete();
    got_q.delete();
    exp_q.delete();
    case (r.kind)
      K_CHALLENGE: begin
        sent_q.push_back(DBG_ACK);
        exp_q.push_back(DBG_ACK);
      end
      K_UART_WRITE: begin
        push_header(CMD_WRITE, r);
        for (int i = 0; i < len; i++) begin
          sent_q.push_back(r.data[i]);
          ref_mem[mem_addr_t'(base + i)] = r.data[i];
        end
        exp_q.push_back(DBG_ACK);
        exp_q.push_back(DBG_EOT);
      end
      K_UART_READ: begin
        exp_q.push_back(DBG_ACK);
        for (int i = 0; i < len; i++) begin
          ref_mem[mem_addr_t'(base + i)] = r.data[i];
          host_write(mem_addr_t'(base + i), r.data[i]);
          exp_q.push_back(r.data[i]);
        end
        exp_q.push_back(DBG_EOT);
        push_header(CMD_READ, r);
      end
      K_EXEC: begin
        push_header(CMD_EXEC, r);
        exp_q.push_back(DBG_ACK);
      end
      default: sent_q.push_back(r.data[0]);
    endcase

    uart_busy = 1'b1;
    fork
      begin
        foreach (sent_q[i]) send_byte(sent_q[i]);
        uart_busy = 1'b0;
      end
      begin
        for (int i = 0; i < exp_q.size(); i++) begin
          recv_byte(b);
          got_q.push_back(b);
        end
      end
      begin
        if (r.kind == K_UART_WRITE) host_traffic(host_base, len);
      end
    join

    // Nothing may follow the expected reply
    expect_silence(QUIET_CYCLES);
    foreach (exp_q[i]) begin
      assert (got_q[i] === exp_q[i]) else begin
        $display("mismatch @%0t: row %0d reply byte %0d got %02h expected %02h",
                 $time, idx, i, got_q[i], exp_q[i]);
        abort_run();
      end
    end

    if (r.kind == K_UART_WRITE) begin
      for (int i = 0; i < len; i++) begin
        check_host_byte(mem_addr_t'(base + i));
        check_host_byte(mem_addr_t'(host_base + i));
      end
    end

    if (r.kind == K_EXEC) begin
      assert (exec_cnt == exec_before + 1 && exec_seen === r.addr) else begin
        $display("mismatch @%0t: row %0d saw %0d exec pulses at %016h, expected one at %016h",
                 $time, idx, exec_cnt - exec_before, exec_seen, r.addr);
        abort_run();
      end
    end else begin
      assert (exec_cnt == exec_before) else begin
        $display("mismatch @%0t: row %0d pulsed the exec output", $time, idx);
        abort_run();
      end
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    uart_rx   = 1'b1;
    host_req  = '0;
    uart_busy = 1'b0;

    rows[0] = make_row(K_CHALLENGE,  64'h0, 0);
    rows[1] = make_row(K_BAD_BYTE,   64'h0, 0);
    rows[1].data[0] = 8'h55;
    rows[2] = make_row(K_CHALLENGE,  64'h0, 0);
    rows[3] = make_row(K_UART_WRITE, 64'h0123_4567_0000_0120, 8);
    // Wraps past the top of the memory
    rows[4] = make_row(K_UART_READ,  64'h0000_0000_0000_03fc, 8);
    rows[5] = make_row(K_EXEC,       64'h8000_1234_5678_9abc, 0);
    rows[6] = make_row(K_UART_WRITE, 64'hffff_ffff_ffff_fff0, 5);
    rows[7] = make_row(K_UART_READ,  64'h0000_0000_0000_00a0, 3);
    rows[8] = make_row(K_CHALLENGE,  64'h0, 0);

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i, rows[i]);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* verilog.f */
logic/uart_dbg_pkg.sv
logic/mem_bus_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/dbg_cmd_engine.sv
logic/mem_arbiter.sv
logic/dbg_sram.sv
logic/dbg_bridge_top.sv
bench/tb_dbg_bridge.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the UART debug bridge testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
  --top-module tb_dbg_bridge --Mdir "$BUILD_DIR" -o sim_tb -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi
